// File: common/pdp8_defines.svh
`ifndef PDP8_DEFINES_SVH
`define PDP8_DEFINES_SVH

// Core memory depth, field 0 only
`define PDP8_MEM_WORDS 4096

// Auto-index locations
`define PDP8_AUTOIDX_LO 12'o0010
`define PDP8_AUTOIDX_HI 12'o0017

// Major opcodes, instruction bits 11:9
`define OPC_AND 3'd0
`define OPC_TAD 3'd1
`define OPC_ISZ 3'd2
`define OPC_DCA 3'd3
`define OPC_JMS 3'd4
`define OPC_JMP 3'd5
`define OPC_IOT 3'd6
`define OPC_OPR 3'd7

`endif

// File: common/pdp8_pkg.sv
`default_nettype none

package pdp8_pkg;

  typedef logic [11:0] word_t;  // Data word or 12-bit address
  typedef logic [4:0]  page_t;  // Upper address bits

  typedef enum logic [1:0] {
    MAJ_FETCH,
    MAJ_DEFER,
    MAJ_EXEC,
    MAJ_HALT
  } major_t;

  // PH_W is the read wait slot between PH_0 and PH_1
  typedef enum logic [2:0] {
    PH_0,
    PH_W,
    PH_1,
    PH_2,
    PH_3
  } phase_t;

  typedef struct packed {
    major_t major;
    phase_t phase;
  } cycle_t;

  typedef struct packed {
    word_t sr;         // Switch register
    logic  load_addr;
    logic  deposit;
    logic  examine;
    logic  run;
  } panel_t;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_LOAD,
    OP_DEP,
    OP_EXAM
  } panel_op_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  we;
  } mem_req_t;

endpackage

`default_nettype wire

// File: src/phase_counter.sv
`timescale 1ns/1ns
`default_nettype none

module phase_counter (
  input  wire              clk,
  input  wire              reset,
  output pdp8_pkg::phase_t phase,
  output logic             cycle_end
);

  import pdp8_pkg::*;

  phase_t phase_next;

  always_comb begin
    case (phase)
      PH_0:    phase_next = PH_W;
      PH_W:    phase_next = PH_1;
      PH_1:    phase_next = PH_2;
      PH_2:    phase_next = PH_3;
      default: phase_next = PH_0;  // Wrap after PH_3
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= PH_0;
    end else begin
      phase <= phase_next;
    end
  end

  assign cycle_end = (phase == PH_3);  // Last slot of the major cycle

  a_phase_legal : assert property (@(posedge clk) disable iff (reset)
    phase inside {PH_0, PH_W, PH_1, PH_2, PH_3})
    else $error("phase 0x%0h out of range", phase);

  a_phase_wrap : assert property (@(posedge clk) disable iff (reset)
    (phase == PH_3) |=> (phase == PH_0))
    else $error("phase did not wrap after PH_3");

  a_phase_step : assert property (@(posedge clk) disable iff (reset)
    (phase != PH_3) |=> (phase == phase_t'($past(phase) + 3'd1)))
    else $error("phase skipped a step");

endmodule

`default_nettype wire

// File: src/cpu_sequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "pdp8_defines.svh"

module cpu_sequencer (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 pdp8_pkg::phase_t phase,
  input  wire                 cycle_end,
  input  wire                 pdp8_pkg::panel_t panel,
  input  wire                 pdp8_pkg::word_t instruction,
  output pdp8_pkg::cycle_t    cycle,
  output pdp8_pkg::panel_op_t panel_op,
  output logic                running
);

  import pdp8_pkg::*;

  localparam int HLT_BIT = 1;  // Group-2 halt

  major_t     major;
  major_t     major_next;
  panel_op_t  pending_op;
  panel_op_t  strobe_op;
  logic       run_pend;
  logic       strobe_run;
  logic       accept;
  logic [2:0] opcode;
  logic       indirect;
  logic       is_hlt;

  assign opcode   = instruction[11:9];
  assign indirect = instruction[8];
  assign is_hlt   = (opcode == `OPC_OPR) && instruction[8] && !instruction[0] &&
                    instruction[HLT_BIT];

  // Strobe priority: load, deposit, examine, then run
  always_comb begin
    strobe_op = OP_NONE;
    if (panel.load_addr) begin
      strobe_op = OP_LOAD;
    end else if (panel.deposit) begin
      strobe_op = OP_DEP;
    end else if (panel.examine) begin
      strobe_op = OP_EXAM;
    end
  end

  assign strobe_run = panel.run && (strobe_op == OP_NONE);

  // Only one command in flight while halted
  assign accept = !running && (pending_op == OP_NONE) && !run_pend &&
                  (panel_op == OP_NONE) && ((strobe_op != OP_NONE) || strobe_run);

  always_comb begin
    major_next = major;
    case (major)
      MAJ_FETCH: begin
        if ((opcode == `OPC_OPR) || (opcode == `OPC_IOT)) begin
          major_next = is_hlt ? MAJ_HALT : MAJ_FETCH;
        end else if (indirect) begin
          major_next = MAJ_DEFER;
        end else begin
          major_next = (opcode == `OPC_JMP) ? MAJ_FETCH : MAJ_EXEC;
        end
      end
      MAJ_DEFER: major_next = (opcode == `OPC_JMP) ? MAJ_FETCH : MAJ_EXEC;
      MAJ_EXEC:  major_next = MAJ_FETCH;
      default: begin
        if (run_pend || (accept && strobe_run)) begin
          major_next = MAJ_FETCH;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      major      <= MAJ_HALT;
      panel_op   <= OP_NONE;
      pending_op <= OP_NONE;
      run_pend   <= 1'b0;
    end else if (cycle_end) begin
      major      <= major_next;
      panel_op   <= (accept && !strobe_run) ? strobe_op : pending_op;  // Active next cycle
      pending_op <= OP_NONE;
      run_pend   <= 1'b0;
    end else if (accept) begin
      pending_op <= strobe_op;
      run_pend   <= strobe_run;
    end
  end

  assign cycle.major = major;
  assign cycle.phase = phase;
  assign running     = (major != MAJ_HALT);

  a_major_on_boundary : assert property (@(posedge clk) disable iff (reset)
    !cycle_end |=> $stable(major))
    else $error("major state changed inside a cycle");

endmodule

`default_nettype wire

// File: ma/ma_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "pdp8_defines.svh"

module ma_unit (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 pdp8_pkg::cycle_t cycle,
  input  wire                 pdp8_pkg::panel_op_t panel_op,
  input  wire                 pdp8_pkg::word_t sr,
  input  wire                 pdp8_pkg::word_t ac,
  input  wire                 pdp8_pkg::word_t rdata,
  output pdp8_pkg::mem_req_t  mem_req,
  output pdp8_pkg::word_t     addr,
  output pdp8_pkg::word_t     instruction,
  output pdp8_pkg::word_t     mdout
);

  import pdp8_pkg::*;

  word_t      pc;
  word_t      eff_addr;
  word_t      wr_value;
  page_t      cur_page;
  logic       we;
  logic       wr_start;
  logic       cap_rd;
  logic       auto_idx;
  logic [2:0] opcode;

  assign opcode   = instruction[11:9];
  assign cur_page = addr[11:7];  // Still the instruction address in fetch PH_3
  assign eff_addr = {(instruction[7] ? cur_page : page_t'(0)), instruction[6:0]};
  assign auto_idx = (addr >= `PDP8_AUTOIDX_LO) && (addr <= `PDP8_AUTOIDX_HI);

  // Read data lands in PH_W; halt cycles keep mdout unless examining
  assign cap_rd = (cycle.phase == PH_W) &&
                  ((cycle.major != MAJ_HALT) || (panel_op == OP_EXAM));

  // Writes are set up in PH_1 and happen at the end of PH_2
  always_comb begin
    wr_start = 1'b0;
    wr_value = mdout + 12'o0001;  // Auto-index and ISZ
    if (cycle.phase == PH_1) begin
      case (cycle.major)
        MAJ_DEFER: wr_start = auto_idx;
        MAJ_EXEC: begin
          case (opcode)
            `OPC_ISZ: wr_start = 1'b1;
            `OPC_DCA: begin
              wr_start = 1'b1;
              wr_value = ac;
            end
            `OPC_JMS: begin
              wr_start = 1'b1;
              wr_value = pc;  // Return address
            end
            default: ;
          endcase
        end
        MAJ_HALT: begin
          if (panel_op == OP_DEP) begin
            wr_start = 1'b1;
            wr_value = sr;
          end
        end
        default: ;
      endcase
    end
  end

  // Memory buffer, also the write data
  always_ff @(posedge clk) begin
    if (cap_rd) begin
      mdout <= rdata;
    end else if (wr_start) begin
      mdout <= wr_value;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      addr        <= '0;
      pc          <= '0;
      instruction <= 12'o7000;
      we          <= 1'b0;
    end else begin
      we <= wr_start;
      case (cycle.phase)
        PH_W: begin
          if (cycle.major == MAJ_FETCH) begin
            instruction <= rdata;
          end
        end
        PH_1: begin
          if (cycle.major == MAJ_FETCH) begin
            pc <= addr + 12'o0001;
          end else if (cycle.major == MAJ_EXEC) begin
            if ((opcode == `OPC_ISZ) && (mdout == 12'o7777)) begin
              pc <= pc + 12'o0001;  // Skip on zero
            end else if (opcode == `OPC_JMS) begin
              pc <= addr + 12'o0001;  // Target plus one
            end
          end else if ((cycle.major == MAJ_HALT) && (panel_op == OP_LOAD)) begin
            addr <= sr;
          end
        end
        PH_2: begin
          if ((cycle.major == MAJ_HALT) &&
              ((panel_op == OP_DEP) || (panel_op == OP_EXAM))) begin
            addr <= addr + 12'o0001;
          end
        end
        PH_3: begin
          case (cycle.major)
            MAJ_FETCH: begin
              if ((opcode == `OPC_OPR) || (opcode == `OPC_IOT)) begin
                addr <= pc;
              end else begin
                addr <= eff_addr;  // Operand, pointer or JMP target
              end
            end
            MAJ_DEFER: addr <= mdout;  // Pointer, already incremented
            MAJ_EXEC:  addr <= pc;
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  assign mem_req.addr  = addr;
  assign mem_req.wdata = mdout;
  assign mem_req.we    = we;

  a_no_write_in_fetch : assert property (@(posedge clk) disable iff (reset)
    (cycle.major == MAJ_FETCH) |-> !mem_req.we)
    else $error("memory write during fetch at 0x%0h", addr);

endmodule

`default_nettype wire

// File: ma/core_memory.sv
`timescale 1ns/1ns
`default_nettype none
`include "pdp8_defines.svh"

module core_memory (
  input  wire                clk,
  input  wire                pdp8_pkg::mem_req_t mem_req,
  output pdp8_pkg::word_t    rdata
);

  import pdp8_pkg::*;

  word_t mem [`PDP8_MEM_WORDS];

  // Read returns the old word on a write to the same address
  always_ff @(posedge clk) begin
    if (mem_req.we) begin
      mem[mem_req.addr] <= mem_req.wdata;
    end
    rdata <= mem[mem_req.addr];
  end

endmodule

`default_nettype wire

// File: src/accumulator.sv
`timescale 1ns/1ns
`default_nettype none
`include "pdp8_defines.svh"

module accumulator (
  input  wire             clk,
  input  wire             reset,
  input  wire             pdp8_pkg::cycle_t cycle,
  input  wire             pdp8_pkg::word_t instruction,
  input  wire             pdp8_pkg::word_t mdout,
  output pdp8_pkg::word_t ac,
  output logic            link
);

  import pdp8_pkg::*;

  localparam int CLA_BIT = 7;
  localparam int CMA_BIT = 5;
  localparam int IAC_BIT = 0;

  word_t      opr_ac;
  logic       opr_link;
  logic [2:0] opcode;
  logic       group1;

  assign opcode = instruction[11:9];
  assign group1 = (opcode == `OPC_OPR) && !instruction[8];

  // Group-1 micro-ops in sequence
  always_comb begin
    {opr_link, opr_ac} = {link, ac};
    if (instruction[CLA_BIT]) begin
      opr_ac = '0;
    end
    if (instruction[CMA_BIT]) begin
      opr_ac = ~opr_ac;
    end
    if (instruction[IAC_BIT]) begin
      {opr_link, opr_ac} = {opr_link, opr_ac} + 13'd1;  // Carry flips link
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ac   <= '0;
      link <= 1'b0;
    end else if ((cycle.major == MAJ_EXEC) && (cycle.phase == PH_2)) begin
      case (opcode)
        `OPC_AND: ac <= ac & mdout;
        `OPC_TAD: {link, ac} <= {link, ac} + {1'b0, mdout};
        `OPC_DCA: ac <= '0;  // Stored in PH_1
        default: ;
      endcase
    end else if ((cycle.major == MAJ_FETCH) && (cycle.phase == PH_3) && group1) begin
      {link, ac} <= {opr_link, opr_ac};
    end
  end

endmodule

`default_nettype wire

// File: src/pdp8_core.sv
`timescale 1ns/1ns
`default_nettype none

module pdp8_core (
  input  wire             clk,
  input  wire             reset,
  input  wire             pdp8_pkg::panel_t panel,
  output pdp8_pkg::word_t addr,
  output pdp8_pkg::word_t mdout,
  output pdp8_pkg::word_t ac,
  output logic            link,
  output logic            running
);

  import pdp8_pkg::*;

  phase_t    phase;
  logic      cycle_end;
  cycle_t    cycle;
  panel_op_t panel_op;
  word_t     instruction;
  word_t     rdata;
  mem_req_t  mem_req;

  phase_counter u_phase (
    .clk       (clk),
    .reset     (reset),
    .phase     (phase),
    .cycle_end (cycle_end)
  );

  cpu_sequencer u_seq (
    .clk         (clk),
    .reset       (reset),
    .phase       (phase),
    .cycle_end   (cycle_end),
    .panel       (panel),
    .instruction (instruction),
    .cycle       (cycle),
    .panel_op    (panel_op),
    .running     (running)
  );

  ma_unit u_ma (
    .clk         (clk),
    .reset       (reset),
    .cycle       (cycle),
    .panel_op    (panel_op),
    .sr          (panel.sr),
    .ac          (ac),        // DCA store data
    .rdata       (rdata),
    .mem_req     (mem_req),
    .addr        (addr),
    .instruction (instruction),
    .mdout       (mdout)
  );

  core_memory u_mem (
    .clk     (clk),
    .mem_req (mem_req),
    .rdata   (rdata)
  );

  accumulator u_acc (
    .clk         (clk),
    .reset       (reset),
    .cycle       (cycle),
    .instruction (instruction),
    .mdout       (mdout),
    .ac          (ac),
    .link        (link)
  );

endmodule

`default_nettype wire

// File: dv/pdp8_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pdp8_core_tb;

  import pdp8_pkg::*;

  localparam int CMD_LIMIT = 20;   // Clocks for one panel command
  localparam int RUN_LIMIT = 400;  // Clocks for a short program

  localparam logic [4:0] CHK_ADDR   = 5'b00001;
  localparam logic [4:0] CHK_MDOUT  = 5'b00010;
  localparam logic [4:0] CHK_AC     = 5'b00100;
  localparam logic [4:0] CHK_LINK   = 5'b01000;
  localparam logic [4:0] CHK_HALTED = 5'b10000;

  logic        clk = 1'b0;
  logic        reset;
  panel_t      panel;
  word_t       addr;
  word_t       mdout;
  word_t       ac;
  logic        link;
  logic        running;

  logic [16:0] lfsr = 17'd89344;
  logic        chk_addr;
  logic        chk_mdout;
  logic        chk_ac;
  logic        chk_link;
  logic        chk_halted;
  word_t       exp_addr;
  word_t       exp_mdout;
  word_t       exp_ac;
  logic        exp_link;
  logic        link_model;  // Link as the instruction rules predict it
  word_t       dep_x;
  word_t       dep_y;
  word_t       op_a;
  word_t       op_b;
  word_t       op_c;
  word_t       ptr_data;
  logic [12:0] tad_sum;

  pdp8_core u_dut (
    .clk     (clk),
    .reset   (reset),
    .panel   (panel),
    .addr    (addr),
    .mdout   (mdout),
    .ac      (ac),
    .link    (link),
    .running (running)
  );

  always #4 clk = ~clk;

  // x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic random_word(output word_t w);
    for (int i = 0; i < 12; i++) begin
      lfsr = lfsr_step(lfsr);
      w[i] = lfsr[0];
    end
  endtask

  task automatic step_clock;
    @(posedge clk);
    #1;
  endtask

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input word_t got, input word_t want);
    fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want));
  endtask

  // Holds the strobe one clock, then counts cycle ends until the halt cycle is done
  task automatic panel_command(input logic [3:0] strobes, input word_t sw);
    int ends;
    int ticks;
    ends  = 0;
    ticks = 0;
    panel.sr = sw;
    {panel.load_addr, panel.deposit, panel.examine, panel.run} = strobes;
    while (ends < 2) begin
      if (u_dut.cycle_end) begin
        ends++;
      end
      step_clock();
      {panel.load_addr, panel.deposit, panel.examine, panel.run} = 4'b0000;
      ticks++;
      if (ticks > CMD_LIMIT) begin
        fail_run("Panel command did not complete in time");
      end
    end
  endtask

  task automatic load_address(input word_t a);
    panel_command(4'b1000, a);
  endtask

  task automatic deposit_word(input word_t w);
    panel_command(4'b0100, w);
  endtask

  task automatic examine_word;
    panel_command(4'b0010, 12'o0000);
  endtask

  task automatic run_program(input word_t start);
    int ticks;
    load_address(start);
    panel.run = 1'b1;
    step_clock();
    panel.run = 1'b0;
    ticks = 0;
    while (!running) begin
      step_clock();
      ticks++;
      if (ticks > CMD_LIMIT) begin
        fail_run("Run strobe did not start the processor");
      end
    end
    ticks = 0;
    while (running) begin
      step_clock();
      ticks++;
      if (ticks > RUN_LIMIT) begin
        fail_run("Program did not reach HLT in time");
      end
    end
  endtask

  // Arms the selected assertions for one clock edge
  task automatic check_outputs(input logic [4:0] which, input word_t a, input word_t md,
                               input word_t acc, input logic l);
    exp_addr  = a;
    exp_mdout = md;
    exp_ac    = acc;
    exp_link  = l;
    {chk_halted, chk_link, chk_ac, chk_mdout, chk_addr} = which;
    step_clock();
    {chk_halted, chk_link, chk_ac, chk_mdout, chk_addr} = 5'b00000;
  endtask

  a_addr : assert property (@(posedge clk) chk_addr |-> (addr == exp_addr))
    else value_mismatch("addr", $sampled(addr), $sampled(exp_addr));

  a_mdout : assert property (@(posedge clk) chk_mdout |-> (mdout == exp_mdout))
    else value_mismatch("mdout", $sampled(mdout), $sampled(exp_mdout));

  a_ac : assert property (@(posedge clk) chk_ac |-> (ac == exp_ac))
    else value_mismatch("ac", $sampled(ac), $sampled(exp_ac));

  a_link : assert property (@(posedge clk) chk_link |-> (link == exp_link))
    else value_mismatch("link", $sampled(link), $sampled(exp_link));

  a_halted : assert property (@(posedge clk) chk_halted |-> !running)
    else value_mismatch("running", $sampled(running), 12'h000);

  initial begin
    reset = 1'b1;
    panel = '0;
    {chk_halted, chk_link, chk_ac, chk_mdout, chk_addr} = 5'b00000;
    exp_addr   = '0;
    exp_mdout  = '0;
    exp_ac     = '0;
    exp_link   = 1'b0;
    link_model = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    check_outputs(CHK_ADDR | CHK_AC | CHK_LINK | CHK_HALTED, 12'o0000, '0, 12'o0000, 1'b0);

    // Panel functions
    random_word(dep_x);
    random_word(dep_y);
    load_address(12'o0100);
    check_outputs(CHK_ADDR, 12'o0100, '0, '0, 1'b0);
    deposit_word(dep_x);
    check_outputs(CHK_ADDR, 12'o0101, '0, '0, 1'b0);
    deposit_word(dep_y);
    check_outputs(CHK_ADDR, 12'o0102, '0, '0, 1'b0);
    load_address(12'o0100);
    examine_word();
    check_outputs(CHK_ADDR | CHK_MDOUT, 12'o0101, dep_x, '0, 1'b0);
    examine_word();
    check_outputs(CHK_ADDR | CHK_MDOUT, 12'o0102, dep_y, '0, 1'b0);

    // AND, TAD and DCA on page-zero and current-page operands
    random_word(op_a);
    random_word(op_b);
    random_word(op_c);
    load_address(12'o0040);
    deposit_word(op_a);
    deposit_word(op_c);
    load_address(12'o0250);
    deposit_word(op_b);
    load_address(12'o0200);
    deposit_word(12'o7200);  // CLA
    deposit_word(12'o1040);  // TAD 0040
    deposit_word(12'o0250);  // AND 0250
    deposit_word(12'o1041);  // TAD 0041
    deposit_word(12'o3251);  // DCA 0251
    deposit_word(12'o7402);  // HLT
    run_program(12'o0200);
    tad_sum    = {1'b0, op_a & op_b} + {1'b0, op_c};
    link_model = link_model ^ tad_sum[12];  // Carry out of the add
    check_outputs(CHK_ADDR | CHK_AC | CHK_LINK | CHK_HALTED, 12'o0206, '0, 12'o0000,
                  link_model);
    load_address(12'o0251);
    examine_word();
    check_outputs(CHK_MDOUT, '0, tad_sum[11:0], '0, 1'b0);

    // Auto-index pointer at 0010 steps to 0300 before use
    random_word(ptr_data);
    load_address(12'o0010);
    deposit_word(12'o0277);
    load_address(12'o0300);
    deposit_word(ptr_data);
    load_address(12'o0400);
    deposit_word(12'o7200);  // CLA
    deposit_word(12'o1410);  // TAD I 0010
    deposit_word(12'o7402);  // HLT
    run_program(12'o0400);
    check_outputs(CHK_ADDR | CHK_AC | CHK_LINK | CHK_HALTED, 12'o0403, '0, ptr_data,
                  link_model);
    load_address(12'o0010);
    examine_word();
    check_outputs(CHK_ADDR | CHK_MDOUT, 12'o0011, 12'o0300, '0, 1'b0);

    // ISZ skip, JMS and return through JMP I
    load_address(12'o0600);
    deposit_word(12'o2250);  // ISZ 0650
    deposit_word(12'o7402);  // Skipped HLT
    deposit_word(12'o4260);  // JMS 0660
    deposit_word(12'o7402);  // HLT after return
    load_address(12'o0650);
    deposit_word(12'o7777);
    load_address(12'o0660);
    deposit_word(12'o0000);  // Return address slot
    deposit_word(12'o5660);  // JMP I 0660
    run_program(12'o0600);
    check_outputs(CHK_ADDR | CHK_HALTED, 12'o0604, '0, '0, 1'b0);
    load_address(12'o0650);
    examine_word();
    check_outputs(CHK_MDOUT, '0, 12'o0000, '0, 1'b0);
    load_address(12'o0660);
    examine_word();
    check_outputs(CHK_MDOUT, '0, 12'o0603, '0, 1'b0);

    // CLA CMA IAC wraps ac to zero and flips link
    load_address(12'o0700);
    deposit_word(12'o7241);
    deposit_word(12'o7402);
    run_program(12'o0700);
    link_model = ~link_model;
    check_outputs(CHK_ADDR | CHK_AC | CHK_LINK | CHK_HALTED, 12'o0702, '0, 12'o0000,
                  link_model);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/pdp8_pkg.sv
src/phase_counter.sv
src/cpu_sequencer.sv
ma/ma_unit.sv
ma/core_memory.sv
src/accumulator.sv
src/pdp8_core.sv
dv/pdp8_core_tb.sv

// File: Bender.yml
package:
  name: pdp8_core

sources:
  - include_dirs:
      - common
    files:
      - common/pdp8_pkg.sv
      - src/phase_counter.sv
      - src/cpu_sequencer.sv
      - ma/ma_unit.sv
      - ma/core_memory.sv
      - src/accumulator.sv
      - src/pdp8_core.sv

  - target: test
    include_dirs:
      - common
    files:
      - dv/pdp8_core_tb.sv
